// ==== logic/cnn_defs.svh ====
`ifndef CNN_DEFS_SVH
`define CNN_DEFS_SVH

// Serial bit time in clocks
`define BAUD_DIV 16

// Picture geometry
`define PIC_SIDE 28
`define POOL_SIDE 14

// Byte memory layout
`define PIC_BASE 0
`define BIAS_ADDR 784
`define POOL_BASE 800
`define RAM_DEPTH 1024
`define ADDR_W 10

// Host file indices
`define FILE_PIC 16'h0000
`define FILE_BIAS 16'h0001
`define FILE_POOL 16'h0002

// Request header bytes, R and W
`define CHAR_READ 8'h52
`define CHAR_WRITE 8'h57

`endif

// ==== logic/cnn_pkg.sv ====
`default_nettype none

`include "cnn_defs.svh"

package cnn_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [`ADDR_W-1:0] addr_t;

    // write set means the node sends the file to the host
    typedef struct packed {
        logic        write;
        logic [15:0] index;
    } file_req_t;

    typedef struct packed {
        logic  en;
        logic  we;
        addr_t addr;
        byte_t wdata;
    } ram_port_t;

endpackage

`default_nettype wire

// ==== logic/uart_link.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module uart_link (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 rx,
    output logic                tx,
    input  wire cnn_pkg::byte_t tx_data,
    input  wire                 tx_en,
    output logic                tx_busy,
    output cnn_pkg::byte_t      rx_data,
    output logic                rx_rdy
);

    localparam int BIT_LAST = `BAUD_DIV - 1;
    localparam int BIT_MID  = `BAUD_DIV / 2 - 1;

    logic [7:0] tx_baud;
    logic [3:0] tx_bit;
    logic [9:0] tx_shift;

    logic [1:0] rx_sync;
    logic       rx_s;
    logic       rx_active;
    logic       rx_sample;
    logic [7:0] rx_baud;
    logic [3:0] rx_bit;
    logic [7:0] rx_shift;

    // Stop, data LSB first, start; shifted out from bit 0
    assign tx = tx_shift[0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_shift <= '1;
            tx_busy  <= 1'b0;
            tx_baud  <= '0;
            tx_bit   <= '0;
        end else if (!tx_busy) begin
            if (tx_en) begin
                tx_shift <= {1'b1, tx_data, 1'b0};
                tx_busy  <= 1'b1;
                tx_baud  <= '0;
                tx_bit   <= '0;
            end
        end else if (tx_baud == 8'(BIT_LAST)) begin
            tx_baud  <= '0;
            tx_shift <= {1'b1, tx_shift[9:1]};
            tx_bit   <= tx_bit + 4'd1;
            if (tx_bit == 4'd9) begin
                tx_busy <= 1'b0;
            end
        end else begin
            tx_baud <= tx_baud + 8'd1;
        end
    end

    assign rx_s      = rx_sync[1];
    assign rx_sample = rx_active && (rx_baud == 8'(BIT_MID));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_sync   <= 2'b11;
            rx_active <= 1'b0;
            rx_baud   <= '0;
            rx_bit    <= '0;
            rx_rdy    <= 1'b0;
        end else begin
            rx_sync <= {rx_sync[0], rx};
            rx_rdy  <= 1'b0;
            if (!rx_active) begin
                if (!rx_s) begin
                    rx_active <= 1'b1;
                    rx_baud   <= '0;
                    rx_bit    <= '0;
                end
            end else begin
                if (rx_sample) begin
                    // Glitch on the start bit
                    if (rx_bit == 4'd0 && rx_s) begin
                        rx_active <= 1'b0;
                    end else if (rx_bit == 4'd9) begin
                        rx_active <= 1'b0;
                        rx_rdy    <= rx_s;
                    end
                end
                if (rx_baud == 8'(BIT_LAST)) begin
                    rx_baud <= '0;
                    rx_bit  <= rx_bit + 4'd1;
                end else begin
                    rx_baud <= rx_baud + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_sample && rx_bit != 4'd0 && rx_bit != 4'd9) begin
            rx_shift <= {rx_s, rx_shift[7:1]};
        end
    end

    assign rx_data = rx_shift;

endmodule

`default_nettype wire

// ==== logic/file_transfer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module file_transfer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     req,
    input  wire cnn_pkg::file_req_t file_req,
    output logic                    xfer_done,
    output cnn_pkg::byte_t          tx_data,
    output logic                    tx_en,
    input  wire                     tx_busy,
    input  wire cnn_pkg::byte_t     rx_data,
    input  wire                     rx_rdy,
    output cnn_pkg::ram_port_t      ram,
    input  wire cnn_pkg::byte_t     ram_rdata
);

    typedef enum logic [2:0] {
        S_IDLE, S_HEAD, S_IDX_HI, S_IDX_LO, S_READ, S_WR_FETCH, S_WR_SEND
    } state_t;

    state_t             state;
    cnn_pkg::file_req_t req_q;
    cnn_pkg::addr_t     addr;
    cnn_pkg::addr_t     count;
    cnn_pkg::addr_t     map_base;
    cnn_pkg::addr_t     map_len;
    logic               tx_ok;
    logic               rd_store;
    logic               wr_fetch;

    // File index to memory range
    always_comb begin
        case (req_q.index)
            `FILE_PIC: begin
                map_base = cnn_pkg::addr_t'(`PIC_BASE);
                map_len  = cnn_pkg::addr_t'(`PIC_SIDE * `PIC_SIDE);
            end
            `FILE_BIAS: begin
                map_base = cnn_pkg::addr_t'(`BIAS_ADDR);
                map_len  = cnn_pkg::addr_t'(1);
            end
            `FILE_POOL: begin
                map_base = cnn_pkg::addr_t'(`POOL_BASE);
                map_len  = cnn_pkg::addr_t'(`POOL_SIDE * `POOL_SIDE);
            end
            default: begin
                map_base = '0;
                map_len  = '0;
            end
        endcase
    end

    // tx_busy lags tx_en by a cycle
    assign tx_ok    = !tx_busy && !tx_en;
    assign rd_store = (state == S_READ) && rx_rdy && (count != map_len);
    assign wr_fetch = (state == S_WR_FETCH) && tx_ok && (count != map_len);

    always_comb begin
        ram.en    = rd_store || wr_fetch;
        ram.we    = rd_store;
        ram.addr  = addr;
        ram.wdata = rx_data;
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req) begin
            req_q <= file_req;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            addr      <= '0;
            count     <= '0;
            tx_en     <= 1'b0;
            tx_data   <= '0;
            xfer_done <= 1'b0;
        end else begin
            tx_en     <= 1'b0;
            xfer_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req) begin
                        state <= S_HEAD;
                    end
                end
                S_HEAD: begin
                    if (tx_ok) begin
                        tx_en   <= 1'b1;
                        tx_data <= req_q.write ? `CHAR_WRITE : `CHAR_READ;
                        state   <= S_IDX_HI;
                    end
                end
                S_IDX_HI: begin
                    if (tx_ok) begin
                        tx_en   <= 1'b1;
                        tx_data <= req_q.index[15:8];
                        state   <= S_IDX_LO;
                    end
                end
                S_IDX_LO: begin
                    if (tx_ok) begin
                        tx_en   <= 1'b1;
                        tx_data <= req_q.index[7:0];
                        addr    <= map_base;
                        count   <= '0;
                        state   <= req_q.write ? S_WR_FETCH : S_READ;
                    end
                end
                S_READ: begin
                    if (count == map_len) begin
                        xfer_done <= 1'b1;
                        state     <= S_IDLE;
                    end else if (rx_rdy) begin
                        addr  <= addr + 1'b1;
                        count <= count + 1'b1;
                        if (count == map_len - 1'b1) begin
                            xfer_done <= 1'b1;
                            state     <= S_IDLE;
                        end
                    end
                end
                S_WR_FETCH: begin
                    if (tx_ok) begin
                        if (count == map_len) begin
                            xfer_done <= 1'b1;
                            state     <= S_IDLE;
                        end else begin
                            state <= S_WR_SEND;
                        end
                    end
                end
                S_WR_SEND: begin
                    tx_en   <= 1'b1;
                    tx_data <= ram_rdata;
                    addr    <= addr + 1'b1;
                    count   <= count + 1'b1;
                    state   <= S_WR_FETCH;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/feature_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module feature_ram (
    input  wire                     clk,
    input  wire cnn_pkg::ram_port_t port_a,
    output cnn_pkg::byte_t          rdata_a,
    input  wire cnn_pkg::ram_port_t port_b,
    output cnn_pkg::byte_t          rdata_b
);

    cnn_pkg::byte_t mem [`RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (port_a.en) begin
            if (port_a.we) begin
                mem[port_a.addr] <= port_a.wdata;
            end else begin
                rdata_a <= mem[port_a.addr];
            end
        end
        if (port_b.en) begin
            if (port_b.we) begin
                mem[port_b.addr] <= port_b.wdata;
            end else begin
                rdata_b <= mem[port_b.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/pool_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module pool_engine (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 pool_start,
    output logic                pool_done,
    output cnn_pkg::ram_port_t  ram,
    input  wire cnn_pkg::byte_t ram_rdata
);

    typedef enum logic [2:0] {
        S_IDLE, S_BIAS_RD, S_BIAS_LAT, S_PIX_RD, S_PIX_ACC, S_WRITE
    } state_t;

    state_t         state;
    logic [3:0]     row;
    logic [3:0]     col;
    logic [1:0]     sub;
    cnn_pkg::byte_t bias;
    cnn_pkg::byte_t max_val;
    logic [4:0]     pix_row;
    logic [4:0]     pix_col;
    cnn_pkg::addr_t pix_addr;
    cnn_pkg::addr_t out_addr;

    // Window pixel: row 2r + sub[1], column 2c + sub[0]
    assign pix_row  = {row, sub[1]};
    assign pix_col  = {col, sub[0]};
    assign pix_addr = cnn_pkg::addr_t'(`PIC_BASE)
                    + cnn_pkg::addr_t'(pix_row) * cnn_pkg::addr_t'(`PIC_SIDE)
                    + cnn_pkg::addr_t'(pix_col);
    assign out_addr = cnn_pkg::addr_t'(`POOL_BASE)
                    + cnn_pkg::addr_t'(row) * cnn_pkg::addr_t'(`POOL_SIDE)
                    + cnn_pkg::addr_t'(col);

    always_comb begin
        ram.en    = 1'b0;
        ram.we    = 1'b0;
        ram.addr  = pix_addr;
        ram.wdata = max_val + bias;
        case (state)
            S_BIAS_RD: begin
                ram.en   = 1'b1;
                ram.addr = cnn_pkg::addr_t'(`BIAS_ADDR);
            end
            S_PIX_RD: ram.en = 1'b1;
            S_WRITE: begin
                ram.en   = 1'b1;
                ram.we   = 1'b1;
                ram.addr = out_addr;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state == S_BIAS_LAT) begin
            bias <= ram_rdata;
        end
        if (state == S_PIX_ACC && (sub == 2'd0 || ram_rdata > max_val)) begin
            max_val <= ram_rdata;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            row       <= '0;
            col       <= '0;
            sub       <= '0;
            pool_done <= 1'b0;
        end else begin
            pool_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (pool_start) begin
                        row   <= '0;
                        col   <= '0;
                        sub   <= '0;
                        state <= S_BIAS_RD;
                    end
                end
                S_BIAS_RD:  state <= S_BIAS_LAT;
                S_BIAS_LAT: state <= S_PIX_RD;
                S_PIX_RD:   state <= S_PIX_ACC;
                S_PIX_ACC: begin
                    sub   <= sub + 2'd1;
                    state <= (sub == 2'd3) ? S_WRITE : S_PIX_RD;
                end
                S_WRITE: begin
                    state <= S_PIX_RD;
                    if (col == 4'(`POOL_SIDE - 1)) begin
                        col <= '0;
                        if (row == 4'(`POOL_SIDE - 1)) begin
                            pool_done <= 1'b1;
                            state     <= S_IDLE;
                        end else begin
                            row <= row + 4'd1;
                        end
                    end else begin
                        col <= col + 4'd1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/layer_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module layer_sequencer (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 start,
    output logic                done,
    output logic                req,
    output cnn_pkg::file_req_t  file_req,
    input  wire                 xfer_done,
    output logic                pool_start,
    input  wire                 pool_done
);

    typedef enum logic [2:0] {
        S_IDLE, S_PIC, S_BIAS, S_POOL, S_RESULT
    } state_t;

    state_t state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= S_IDLE;
            done       <= 1'b0;
            req        <= 1'b0;
            pool_start <= 1'b0;
            file_req   <= '0;
        end else begin
            req        <= 1'b0;
            pool_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        done           <= 1'b0;
                        req            <= 1'b1;
                        file_req.write <= 1'b0;
                        file_req.index <= `FILE_PIC;
                        state          <= S_PIC;
                    end
                end
                S_PIC: begin
                    if (xfer_done) begin
                        req            <= 1'b1;
                        file_req.write <= 1'b0;
                        file_req.index <= `FILE_BIAS;
                        state          <= S_BIAS;
                    end
                end
                S_BIAS: begin
                    if (xfer_done) begin
                        pool_start <= 1'b1;
                        state      <= S_POOL;
                    end
                end
                S_POOL: begin
                    if (pool_done) begin
                        req            <= 1'b1;
                        file_req.write <= 1'b1;
                        file_req.index <= `FILE_POOL;
                        state          <= S_RESULT;
                    end
                end
                S_RESULT: begin
                    // Last result byte has left the line
                    if (xfer_done) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/cnn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_top (
    input  wire  clk,
    input  wire  reset,
    input  wire  rx,
    output logic tx,
    input  wire  start,
    output logic done
);

    cnn_pkg::byte_t     tx_data;
    logic               tx_en;
    logic               tx_busy;
    cnn_pkg::byte_t     rx_data;
    logic               rx_rdy;
    logic               req;
    cnn_pkg::file_req_t file_req;
    logic               xfer_done;
    logic               pool_start;
    logic               pool_done;
    cnn_pkg::ram_port_t port_a;
    cnn_pkg::ram_port_t port_b;
    cnn_pkg::byte_t     rdata_a;
    cnn_pkg::byte_t     rdata_b;

    uart_link u_uart (
        .clk(clk), .reset(reset), .rx(rx), .tx(tx),
        .tx_data(tx_data), .tx_en(tx_en), .tx_busy(tx_busy),
        .rx_data(rx_data), .rx_rdy(rx_rdy)
    );

    file_transfer u_xfer (
        .clk(clk), .reset(reset), .req(req), .file_req(file_req), .xfer_done(xfer_done),
        .tx_data(tx_data), .tx_en(tx_en), .tx_busy(tx_busy),
        .rx_data(rx_data), .rx_rdy(rx_rdy), .ram(port_a), .ram_rdata(rdata_a)
    );

    // Transfer engine on port a, pool engine on port b
    feature_ram u_ram (
        .clk(clk), .port_a(port_a), .rdata_a(rdata_a), .port_b(port_b), .rdata_b(rdata_b)
    );

    pool_engine u_pool (
        .clk(clk), .reset(reset), .pool_start(pool_start), .pool_done(pool_done),
        .ram(port_b), .ram_rdata(rdata_b)
    );

    layer_sequencer u_seq (
        .clk(clk), .reset(reset), .start(start), .done(done), .req(req),
        .file_req(file_req), .xfer_done(xfer_done),
        .pool_start(pool_start), .pool_done(pool_done)
    );

endmodule

`default_nettype wire

// ==== dv/cnn_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cnn_defs.svh"

module cnn_tb;

    localparam int CLK_NS       = 40;
    localparam int PIC_BYTES    = `PIC_SIDE * `PIC_SIDE;
    localparam int RECV_TIMEOUT = 4000;
    localparam int DONE_TIMEOUT = 10 * `BAUD_DIV;
    // Two passes of 1000 serial bytes, with half again as margin
    localparam int WATCHDOG_NS  = 2 * 1000 * 10 * `BAUD_DIV * CLK_NS * 3 / 2;

    logic clk;
    logic reset;
    logic rx;
    logic start;
    wire  tx;
    wire  done;

    int             errors;
    int             checks;
    logic [31:0]    lcg_state;
    cnn_pkg::byte_t cur_bias;
    cnn_pkg::byte_t picture [PIC_BYTES];
    cnn_pkg::byte_t tx_bytes [$];

    cnn_top dut (
        .clk(clk), .reset(reset), .rx(rx), .tx(tx), .start(start), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    function automatic cnn_pkg::byte_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // Unsigned 2x2 maximum plus bias, wrapping at 256
    function automatic cnn_pkg::byte_t pooled_value(input int r, input int c,
                                                   input cnn_pkg::byte_t bias);
        cnn_pkg::byte_t m;
        cnn_pkg::byte_t p;
        m = 8'h00;
        for (int dr = 0; dr < 2; dr++) begin
            for (int dc = 0; dc < 2; dc++) begin
                p = picture[(2 * r + dr) * `PIC_SIDE + 2 * c + dc];
                if (p > m) begin
                    m = p;
                end
            end
        end
        return m + bias;
    endfunction

    task automatic compare_byte(input string name, input cnn_pkg::byte_t expected,
                                input cnn_pkg::byte_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
        end
    endtask

    task automatic send_byte(input cnn_pkg::byte_t value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (`BAUD_DIV) @(posedge clk);
            #2;
        end
    endtask

    // Host receiver, samples each tx bit at its middle
    task automatic watch_tx();
        cnn_pkg::byte_t data;
        forever begin
            @(posedge clk);
            #2;
            if (tx === 1'b0) begin
                repeat (`BAUD_DIV / 2) @(posedge clk);
                #2;
                if (tx !== 1'b0) begin
                    errors++;
                    $display("Start bit on tx did not stay low to its middle");
                end else begin
                    for (int i = 0; i < 8; i++) begin
                        repeat (`BAUD_DIV) @(posedge clk);
                        #2;
                        data[i] = tx;
                    end
                    repeat (`BAUD_DIV) @(posedge clk);
                    #2;
                    if (tx !== 1'b1) begin
                        errors++;
                        $display("Bad stop bit on tx, the line was low");
                    end else begin
                        tx_bytes.push_back(data);
                    end
                end
            end
        end
    endtask

    task automatic recv_byte(output cnn_pkg::byte_t value);
        int waited;
        waited = 0;
        while (tx_bytes.size() == 0 && waited < RECV_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (tx_bytes.size() == 0) begin
            errors++;
            $display("No byte arrived from the DUT on tx within %0d cycles", RECV_TIMEOUT);
            value = 8'h00;
        end else begin
            value = tx_bytes.pop_front();
        end
    endtask

    task automatic expect_byte(input string name, input cnn_pkg::byte_t expected);
        cnn_pkg::byte_t got;
        recv_byte(got);
        compare_byte(name, expected, got);
    endtask

    task automatic pulse_start();
        @(posedge clk);
        #2;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
    endtask

    task automatic test_reset_state();
        repeat (50) begin
            @(posedge clk);
            #2;
            compare_flag("tx", 1'b1, tx);
            compare_flag("done", 1'b0, done);
        end
    endtask

    // Start a pass, answer the picture and bias requests
    task automatic test_read_requests(input cnn_pkg::byte_t bias);
        for (int i = 0; i < PIC_BYTES; i++) begin
            picture[i] = next_random();
        end
        cur_bias = bias;
        pulse_start();
        compare_flag("done", 1'b0, done);
        expect_byte("picture header", `CHAR_READ);
        expect_byte("picture index high", 8'h00);
        expect_byte("picture index low", 8'h00);
        for (int i = 0; i < PIC_BYTES; i++) begin
            send_byte(picture[i]);
        end
        expect_byte("bias header", `CHAR_READ);
        expect_byte("bias index high", 8'h00);
        expect_byte("bias index low", 8'h01);
        send_byte(bias);
    endtask

    task automatic test_result_header();
        expect_byte("result header", `CHAR_WRITE);
        expect_byte("result index high", 8'h00);
        expect_byte("result index low", 8'h02);
    endtask

    task automatic test_result_data();
        for (int r = 0; r < `POOL_SIDE; r++) begin
            for (int c = 0; c < `POOL_SIDE; c++) begin
                expect_byte($sformatf("result[%0d][%0d]", r, c), pooled_value(r, c, cur_bias));
            end
        end
    endtask

    task automatic test_done_rises();
        int waited;
        waited = 0;
        while (done !== 1'b1 && waited < DONE_TIMEOUT) begin
            @(posedge clk);
            #2;
            waited++;
        end
        compare_flag("done", 1'b1, done);
    endtask

    task automatic test_second_pass();
        test_read_requests(8'h00);
        test_result_header();
        test_result_data();
        test_done_rises();
    endtask

    initial begin
        @(negedge reset);
        watch_tx();
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the DUT did not finish both passes", WATCHDOG_NS);
        $display("%0d checks, %0d errors", checks, errors);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        errors    = 0;
        checks    = 0;
        lcg_state = 32'd1;
        cur_bias  = 8'h00;
        reset     = 1'b1;
        rx        = 1'b1;
        start     = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;

        test_reset_state();
        // Bias 0xF0 makes most sums wrap
        test_read_requests(8'hF0);
        test_result_header();
        test_result_data();
        test_done_rises();
        test_second_pass();

        repeat (10) @(posedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+logic
logic/cnn_pkg.sv
logic/uart_link.sv
logic/file_transfer.sv
logic/feature_ram.sv
logic/pool_engine.sv
logic/layer_sequencer.sv
logic/cnn_top.sv
dv/cnn_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module cnn_tb -f list.f --Mdir obj_dir -o cnn_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cnn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0
